/* logic/eq_cfg.svh */
`ifndef EQ_CFG_SVH
`define EQ_CFG_SVH

// Filter geometry
`define EQ_NUM_TAPS     11
`define EQ_CENTER_TAP   5    // Tap holding 1.0 after reset

// Input samples, S(8,7)
`define EQ_NBT_IN       8
`define EQ_NBF_IN       7

// Coefficients, S(28,25)
`define EQ_NBT_TAP      28
`define EQ_NBF_TAP      25

// Equalized samples, S(12,9)
`define EQ_NBT_OUT      12
`define EQ_NBF_OUT      9

// Slicer error, same fraction as the output
`define EQ_NBT_ERR      12

// LMS step of 2^-8
`define EQ_STEP_SHIFT   8

// Decision magnitude in output format
`define EQ_SLICE_LEVEL  256  // 0.5

`endif

/* logic/eq_pkg.sv */
`default_nettype none

`include "eq_cfg.svh"

package eq_pkg;

  // Scalar formats
  typedef logic signed [`EQ_NBT_IN-1:0]  sample_t;  // S(8,7)
  typedef logic signed [`EQ_NBT_TAP-1:0] tap_t;     // S(28,25)
  typedef logic signed [`EQ_NBT_OUT-1:0] out_t;     // S(12,9)
  typedef logic signed [`EQ_NBT_ERR-1:0] err_t;     // Fraction 9

  // Full product is 36 bits; four guard bits cover eleven terms
  typedef logic signed [`EQ_NBT_IN+`EQ_NBT_TAP+3:0] acc_t;

  // Per-rail collections
  typedef sample_t window_t [`EQ_NUM_TAPS];  // Index 0 is the newest sample
  typedef tap_t    taps_t   [`EQ_NUM_TAPS];

endpackage

`default_nettype wire

/* logic/eq_delay_line.sv */
`timescale 1ns/10ps
`default_nettype none

`include "eq_cfg.svh"

module eq_delay_line (
  input  wire logic             clk,
  input  wire logic             i_rst,
  input  wire logic             i_en,      // One pulse per sample
  input  wire eq_pkg::sample_t  i_sample,
  output eq_pkg::window_t       o_window
);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_window <= '{default: '0};
    end else if (i_en) begin
      o_window[0] <= i_sample;               // Newest at the head
      for (int k = 1; k < `EQ_NUM_TAPS; k++) begin
        o_window[k] <= o_window[k-1];        // Age by one sample
      end
    end
  end

  // The filter and the LMS snapshot both rely on the window holding between strobes
  for (genvar k = 0; k < `EQ_NUM_TAPS; k++) begin : g_hold_chk
    a_window_hold: assert property (
      @(posedge clk) disable iff (i_rst)
      !i_en |=> $stable(o_window[k])
    ) else $error("window slot %0d moved without a sample strobe", k);
  end

endmodule

`default_nettype wire

/* logic/fse_fir.sv */
`timescale 1ns/10ps
`default_nettype none

`include "eq_cfg.svh"

module fse_fir (
  input  wire logic             clk,
  input  wire logic             i_rst,
  input  wire logic             i_en_rate2,
  input  wire logic             i_en_rate1,
  input  wire eq_pkg::window_t  i_window_i,
  input  wire eq_pkg::window_t  i_window_q,
  input  wire eq_pkg::taps_t    i_taps_i,
  input  wire eq_pkg::taps_t    i_taps_q,
  output eq_pkg::out_t          o_data_i,
  output eq_pkg::out_t          o_data_q,
  output logic                  o_sym_valid
);

  import eq_pkg::*;

  // Product fraction 7 + 25 = 32, output fraction 9
  localparam int   RND_SHIFT = `EQ_NBF_IN + `EQ_NBF_TAP - `EQ_NBF_OUT;
  localparam acc_t RND_HALF  = acc_t'(1) <<< (RND_SHIFT - 1);
  localparam acc_t OUT_MAX   = acc_t'(2**(`EQ_NBT_OUT-1) - 1);
  localparam acc_t OUT_MIN   = -acc_t'(2**(`EQ_NBT_OUT-1));

  out_t w_fir_i;
  out_t w_fir_q;

  function automatic out_t fir_out(window_t win, taps_t taps);
    acc_t sum;
    acc_t rnd;
    sum = '0;
    for (int k = 0; k < `EQ_NUM_TAPS; k++) begin
      sum += acc_t'(win[k]) * acc_t'(taps[k]);  // Full precision MAC
    end
    rnd = (sum + RND_HALF) >>> RND_SHIFT;       // Round half up
    if (rnd > OUT_MAX) begin
      return out_t'(OUT_MAX);
    end else if (rnd < OUT_MIN) begin
      return out_t'(OUT_MIN);
    end
    return out_t'(rnd);
  endfunction

  // Each rail uses only its own taps
  assign w_fir_i = fir_out(i_window_i, i_taps_i);
  assign w_fir_q = fir_out(i_window_q, i_taps_q);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_data_i    <= '0;
      o_data_q    <= '0;
      o_sym_valid <= 1'b0;
    end else begin
      o_sym_valid <= i_en_rate1;             // Tags the update that carries a symbol
      if (i_en_rate2) begin
        o_data_i <= w_fir_i;                 // Pre-edge window and taps
        o_data_q <= w_fir_q;
      end
    end
  end

  a_rate1_in_rate2: assert property (
    @(posedge clk) disable iff (i_rst)
    i_en_rate1 |-> i_en_rate2
  ) else $error("symbol strobe without a sample strobe");

  // Filter, slicer and tap update need four cycles per sample
  a_rate2_spacing: assert property (
    @(posedge clk) disable iff (i_rst)
    i_en_rate2 |=> !i_en_rate2 [*3]
  ) else $error("sample strobes closer than four cycles");

endmodule

`default_nettype wire

/* logic/lms_update.sv */
`timescale 1ns/10ps
`default_nettype none

`include "eq_cfg.svh"

module lms_update (
  input  wire logic             clk,
  input  wire logic             i_rst,
  input  wire logic             i_en_rate1,
  input  wire logic             i_err_valid,
  input  wire eq_pkg::window_t  i_window_i,
  input  wire eq_pkg::window_t  i_window_q,
  input  wire eq_pkg::err_t     i_err_i,
  input  wire eq_pkg::err_t     i_err_q,
  output eq_pkg::taps_t         o_taps_i,
  output eq_pkg::taps_t         o_taps_q
);

  import eq_pkg::*;

  // Error times sample has fraction 9 + 7 = 16, taps have 25
  localparam int   ALIGN   = `EQ_NBF_TAP - `EQ_NBF_OUT - `EQ_NBF_IN;
  localparam int   PROD_W  = `EQ_NBT_ERR + `EQ_NBT_IN;
  localparam int   WIDE_W  = `EQ_NBT_TAP + 1;
  localparam tap_t TAP_ONE = tap_t'(1) <<< `EQ_NBF_TAP;

  localparam logic signed [WIDE_W-1:0] TAP_MAX =
    WIDE_W'({1'b0, {(`EQ_NBT_TAP-1){1'b1}}});
  localparam logic signed [WIDE_W-1:0] TAP_MIN = -TAP_MAX - 1;

  window_t r_snap_i;                         // Window that produced the current symbol
  window_t r_snap_q;

  function automatic tap_t lms_step(tap_t tap, err_t err, sample_t smp);
    logic signed [PROD_W-1:0] prod;
    logic signed [WIDE_W-1:0] inc;
    logic signed [WIDE_W-1:0] next;
    prod = err * smp;                                  // S(20,16)
    inc  = WIDE_W'(prod >>> `EQ_STEP_SHIFT) <<< ALIGN; // Floor, then to tap format
    next = WIDE_W'(tap) - inc;
    if (next > TAP_MAX) begin
      return tap_t'(TAP_MAX);
    end else if (next < TAP_MIN) begin
      return tap_t'(TAP_MIN);
    end
    return tap_t'(next);
  endfunction

  // Captured before the delay line shifts on the same edge
  always_ff @(posedge clk) begin
    if (i_en_rate1) begin
      r_snap_i <= i_window_i;
      r_snap_q <= i_window_q;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int k = 0; k < `EQ_NUM_TAPS; k++) begin
        o_taps_i[k] <= (k == `EQ_CENTER_TAP) ? TAP_ONE : '0;  // Center spike
        o_taps_q[k] <= (k == `EQ_CENTER_TAP) ? TAP_ONE : '0;
      end
    end else if (i_err_valid) begin
      for (int k = 0; k < `EQ_NUM_TAPS; k++) begin
        o_taps_i[k] <= lms_step(o_taps_i[k], i_err_i, r_snap_i[k]);
        o_taps_q[k] <= lms_step(o_taps_q[k], i_err_q, r_snap_q[k]);
      end
    end
  end

  // Error must belong to the symbol whose window sits in the snapshot
  a_err_follows_sym: assert property (
    @(posedge clk) disable iff (i_rst)
    i_err_valid |-> $past(i_en_rate1, 2)
  ) else $error("error strobe not two cycles after a symbol strobe");

  for (genvar k = 0; k < `EQ_NUM_TAPS; k++) begin : g_tap_chk
    a_tap_hold: assert property (
      @(posedge clk) disable iff (i_rst)
      !i_err_valid |=> ($stable(o_taps_i[k]) && $stable(o_taps_q[k]))
    ) else $error("tap %0d changed without an error strobe", k);
  end

endmodule

`default_nettype wire

/* logic/qpsk_slicer_error.sv */
`timescale 1ns/10ps
`default_nettype none

`include "eq_cfg.svh"

module qpsk_slicer_error (
  input  wire logic          clk,
  input  wire logic          i_rst,
  input  wire logic          i_sym_valid,
  input  wire eq_pkg::out_t  i_sym_i,
  input  wire eq_pkg::out_t  i_sym_q,
  output eq_pkg::err_t       o_err_i,
  output eq_pkg::err_t       o_err_q,
  output logic               o_err_valid
);

  import eq_pkg::*;

  localparam out_t LEVEL = out_t'(`EQ_SLICE_LEVEL);  // 0.5 in S(12,9)

  // Range stays within +-1792, so the difference never wraps
  function automatic err_t slice_err(out_t sym);
    out_t decision;
    decision = sym[`EQ_NBT_OUT-1] ? -LEVEL : LEVEL;  // Zero counts as positive
    return err_t'(sym - decision);
  endfunction

  always_ff @(posedge clk) begin
    if (i_sym_valid) begin
      o_err_i <= slice_err(i_sym_i);
      o_err_q <= slice_err(i_sym_q);
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_err_valid <= 1'b0;
    end else begin
      o_err_valid <= i_sym_valid;            // One pulse per decided symbol
    end
  end

endmodule

`default_nettype wire

/* logic/adaptive_equalizer.sv */
`timescale 1ns/10ps
`default_nettype none

module adaptive_equalizer (
  input  wire logic             clk,
  input  wire logic             i_rst,
  input  wire logic             i_en_rate2,  // Sample strobe
  input  wire logic             i_en_rate1,  // Symbol strobe, subset of rate2
  input  wire eq_pkg::sample_t  i_data_i,
  input  wire eq_pkg::sample_t  i_data_q,
  output eq_pkg::out_t          o_data_i,
  output eq_pkg::out_t          o_data_q,
  output logic                  o_sym_valid,
  output eq_pkg::out_t          o_sym_i,
  output eq_pkg::out_t          o_sym_q
);

  import eq_pkg::*;

  window_t w_window_i;
  window_t w_window_q;
  taps_t   w_taps_i;
  taps_t   w_taps_q;
  out_t    w_data_i;
  out_t    w_data_q;
  logic    w_sym_valid;
  err_t    w_err_i;
  err_t    w_err_q;
  logic    w_err_valid;

  eq_delay_line u_dl_i (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_en     (i_en_rate2),
    .i_sample (i_data_i),
    .o_window (w_window_i)
  );

  eq_delay_line u_dl_q (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_en     (i_en_rate2),
    .i_sample (i_data_q),
    .o_window (w_window_q)
  );

  fse_fir u_fse_fir (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_en_rate2  (i_en_rate2),
    .i_en_rate1  (i_en_rate1),
    .i_window_i  (w_window_i),
    .i_window_q  (w_window_q),
    .i_taps_i    (w_taps_i),      // Straight hookup, no cross-coupling
    .i_taps_q    (w_taps_q),
    .o_data_i    (w_data_i),
    .o_data_q    (w_data_q),
    .o_sym_valid (w_sym_valid)
  );

  qpsk_slicer_error u_slicer (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_sym_valid (w_sym_valid),
    .i_sym_i     (w_data_i),
    .i_sym_q     (w_data_q),
    .o_err_i     (w_err_i),
    .o_err_q     (w_err_q),
    .o_err_valid (w_err_valid)
  );

  lms_update u_lms (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_en_rate1  (i_en_rate1),
    .i_err_valid (w_err_valid),
    .i_window_i  (w_window_i),
    .i_window_q  (w_window_q),
    .i_err_i     (w_err_i),
    .i_err_q     (w_err_q),
    .o_taps_i    (w_taps_i),
    .o_taps_q    (w_taps_q)
  );

  assign o_data_i    = w_data_i;
  assign o_data_q    = w_data_q;
  assign o_sym_valid = w_sym_valid;
  assign o_sym_i     = w_data_i;       // Symbol is the tagged filter output
  assign o_sym_q     = w_data_q;

endmodule

`default_nettype wire

/* dv/tb_adaptive_equalizer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "eq_cfg.svh"

module tb_adaptive_equalizer;

  import eq_pkg::*;

  // Run is about 41000 cycles and mostly adaptation
  localparam int     TIMEOUT_CYCLES = 125000;
  localparam int     ADAPT_SAMPLES  = 10000;   // Roughly 1.2 LMS time constants
  localparam int     OUT_SHIFT      = `EQ_NBF_IN + `EQ_NBF_TAP - `EQ_NBF_OUT;
  localparam int     TAP_ALIGN      = `EQ_NBF_TAP - `EQ_NBF_OUT - `EQ_NBF_IN;
  localparam longint OUT_HI         = (longint'(1) << (`EQ_NBT_OUT - 1)) - 1;
  localparam longint TAP_HI         = (longint'(1) << (`EQ_NBT_TAP - 1)) - 1;
  localparam longint LEVEL          = `EQ_SLICE_LEVEL;

  logic    clk;
  logic    rst;
  logic    en_rate2;
  logic    en_rate1;
  sample_t din_i;
  sample_t din_q;
  out_t    dout_i;
  out_t    dout_q;
  logic    sym_valid;
  out_t    sym_i;
  out_t    sym_q;

  longint  win_i  [`EQ_NUM_TAPS];   // Model window with index 0 newest
  longint  win_q  [`EQ_NUM_TAPS];
  longint  taps_i [`EQ_NUM_TAPS];
  longint  taps_q [`EQ_NUM_TAPS];
  longint  exp_i;
  longint  exp_q;
  longint  sym_dist [$];            // Per-symbol distance from the decision level

  int      strobe_cnt;
  int      rate1_cnt;
  int      pulse_cnt;
  int      cycle_cnt;
  bit      last_sym;

  adaptive_equalizer adaptive_equalizer_i (
    .clk         (clk),
    .i_rst       (rst),
    .i_en_rate2  (en_rate2),
    .i_en_rate1  (en_rate1),
    .i_data_i    (din_i),
    .i_data_q    (din_q),
    .o_data_i    (dout_i),
    .o_data_q    (dout_q),
    .o_sym_valid (sym_valid),
    .o_sym_i     (sym_i),
    .o_sym_q     (sym_q)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("Timeout: tests still running after %0d cycles", cycle_cnt));
    end
  end

  // Every symbol pulse must carry the current filter output
  always @(negedge clk) begin
    if (!rst && sym_valid) begin
      pulse_cnt++;
      check("o_sym_i", sym_i, dout_i);
      check("o_sym_q", sym_q, dout_q);
    end
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic signed [63:0] got,
                       input logic signed [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic longint clamp(longint v, longint hi);
    return (v > hi) ? hi : ((v < -hi - 1) ? -hi - 1 : v);
  endfunction

  // Fraction 32 down to 9 with round half up
  function automatic longint output_of(longint acc);
    return clamp((acc + (longint'(1) << (OUT_SHIFT - 1))) >>> OUT_SHIFT, OUT_HI);
  endfunction

  function automatic longint slicer_error(longint sym);
    return sym - ((sym >= 0) ? LEVEL : -LEVEL);
  endfunction

  function automatic longint next_tap(longint tap, longint err, longint smp);
    longint inc;
    inc = ((err * smp) >>> `EQ_STEP_SHIFT) << TAP_ALIGN;  // Floor then align
    return clamp(tap - inc, TAP_HI);
  endfunction

  function automatic longint level_distance(longint s);
    longint mag;
    mag = (s < 0) ? -s : s;
    return (mag > LEVEL) ? mag - LEVEL : LEVEL - mag;
  endfunction

  function automatic longint rand_sign(longint mag);
    return ($urandom() & 1) ? mag : -mag;
  endfunction

  task automatic model_reset();
    for (int k = 0; k < `EQ_NUM_TAPS; k++) begin
      win_i[k]  = 0;
      win_q[k]  = 0;
      taps_i[k] = (k == `EQ_CENTER_TAP) ? (longint'(1) << `EQ_NBF_TAP) : 0;
      taps_q[k] = taps_i[k];
    end
  endtask

  // One sample strobe filters, runs LMS on symbols, then shifts
  task automatic model_step(input longint x_i, input longint x_q, input bit sym);
    longint acc_i;
    longint acc_q;
    longint err_i;
    longint err_q;
    acc_i = 0;
    acc_q = 0;
    for (int k = 0; k < `EQ_NUM_TAPS; k++) begin
      acc_i += win_i[k] * taps_i[k];
      acc_q += win_q[k] * taps_q[k];
    end
    exp_i = output_of(acc_i);
    exp_q = output_of(acc_q);
    if (sym) begin
      err_i = slicer_error(exp_i);
      err_q = slicer_error(exp_q);
      for (int k = 0; k < `EQ_NUM_TAPS; k++) begin
        taps_i[k] = next_tap(taps_i[k], err_i, win_i[k]);  // Pre-shift window
        taps_q[k] = next_tap(taps_q[k], err_q, win_q[k]);
      end
    end
    for (int k = `EQ_NUM_TAPS - 1; k > 0; k--) begin
      win_i[k] = win_i[k-1];
      win_q[k] = win_q[k-1];
    end
    win_i[0] = x_i;
    win_q[0] = x_q;
  endtask

  // Starts and ends on a falling edge four cycles apart
  task automatic send_sample(input longint x_i, input longint x_q);
    bit sym;
    sym      = (strobe_cnt % 2 == 0);    // Every second sample is a symbol
    din_i    = sample_t'(x_i);
    din_q    = sample_t'(x_q);
    en_rate2 = 1'b1;
    en_rate1 = sym;
    model_step(x_i, x_q, sym);
    @(negedge clk);
    en_rate2 = 1'b0;
    en_rate1 = 1'b0;
    check("o_data_i", dout_i, exp_i);
    check("o_data_q", dout_q, exp_q);
    check("o_sym_valid", sym_valid, sym);
    strobe_cnt++;
    rate1_cnt += sym;
    last_sym = sym;
    repeat (3) begin
      @(negedge clk);
      check("o_sym_valid", sym_valid, 0);
    end
  endtask

  task automatic reset_values();
    check("o_data_i", dout_i, 0);
    check("o_data_q", dout_q, 0);
    check("o_sym_i", sym_i, 0);
    check("o_sym_q", sym_q, 0);
    repeat (4) begin
      @(negedge clk);
      check("o_sym_valid", sym_valid, 0);
    end
  endtask

  // Start-up symbols see a half empty window, so the taps move a little
  task automatic pass_through();
    repeat (60) begin
      send_sample(rand_sign(64), rand_sign(64));
    end
  endtask

  task automatic rate_gating();
    repeat (20) begin
      din_i = sample_t'($urandom());
      din_q = sample_t'($urandom());
      @(negedge clk);
      check("o_data_i", dout_i, exp_i);
      check("o_data_q", dout_q, exp_q);
      check("o_sym_i", sym_i, exp_i);
      check("o_sym_q", sym_q, exp_q);
    end
  endtask

  task automatic decimation();
    int pulses0;
    int strobes0;
    pulses0  = pulse_cnt;
    strobes0 = rate1_cnt;
    repeat (100) begin
      send_sample(rand_sign(64), rand_sign(64));
    end
    check("o_sym_valid pulse count", pulse_cnt - pulses0, rate1_cnt - strobes0);
  endtask

  task automatic adaptation();
    longint early;
    longint late;
    sym_dist.delete();
    for (int n = 0; n < ADAPT_SAMPLES; n++) begin
      send_sample(rand_sign(32), rand_sign(32));
      if (n >= `EQ_NUM_TAPS && last_sym) begin   // Window holds only this phase
        sym_dist.push_back(level_distance(sym_i) + level_distance(sym_q));
      end
    end
    early = 0;
    late  = 0;
    for (int k = 0; k < 20; k++) begin
      early += sym_dist[k];
      late  += sym_dist[sym_dist.size() - 1 - k];
    end
    if (2 * late >= early) begin
      stop_on_error($sformatf("Equalizer did not adapt: distance %0d early, %0d late",
                              early, late));
    end
  endtask

  task automatic saturation();
    for (int n = 0; n < 40; n++) begin
      send_sample(-128, -128);
      if (n >= `EQ_NUM_TAPS) begin
        check("o_data_i above zero", dout_i > 0, 0);
        check("o_data_q above zero", dout_q > 0, 0);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hb76d));
    clk        = 1'b0;
    rst        = 1'b1;
    en_rate2   = 1'b0;
    en_rate1   = 1'b0;
    din_i      = '0;
    din_q      = '0;
    strobe_cnt = 0;
    rate1_cnt  = 0;
    pulse_cnt  = 0;
    cycle_cnt  = 0;
    last_sym   = 1'b0;
    model_reset();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    reset_values();
    pass_through();
    rate_gating();
    decimation();
    adaptation();
    saturation();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/eq_pkg.sv
logic/eq_delay_line.sv
logic/fse_fir.sv
logic/lms_update.sv
logic/qpsk_slicer_error.sv
logic/adaptive_equalizer.sv
dv/tb_adaptive_equalizer.sv

/* Bender.yml */
package:
  name: adaptive_equalizer

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/eq_pkg.sv
      - logic/eq_delay_line.sv
      - logic/fse_fir.sv
      - logic/lms_update.sv
      - logic/qpsk_slicer_error.sv
      - logic/adaptive_equalizer.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/tb_adaptive_equalizer.sv
